// ==== Makefile ====
# Verilator flow for the CCE core testbench
VERILATOR ?= verilator
TOP       ?= tb_cce_top
RTL_TOP   ?= cce_top
FILELIST  ?= cce_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= *** TEST PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== cce_assert_checker.sv ====
/*
  protocol assertions for cce_top, attached with bind
  handshake checks are disabled during reset
  outputs are checked from the second reset cycle, once run state has cleared
*/
`timescale 1ns/1ps

module cce_assert_checker
  (input   clk_i
   , input reset_i
   , input req_v_i
   , input req_ready_i
   , input resp_v_i
   , input resp_ready_i
   , input cmd_v_i
   , input cmd_ready_i
   , input data_v_i
   , input data_ready_i
   , input halted_i
  );

  // push valid only with ready
  cmd_v_ready_a: assert property (@(posedge clk_i) disable iff (reset_i)
    cmd_v_i |-> cmd_ready_i) else $error("command valid without ready");
  data_v_ready_a: assert property (@(posedge clk_i) disable iff (reset_i)
    data_v_i |-> data_ready_i) else $error("data valid without ready");

  // pop ready only with valid
  req_ready_v_a: assert property (@(posedge clk_i) disable iff (reset_i)
    req_ready_i |-> req_v_i) else $error("request ready without valid");
  resp_ready_v_a: assert property (@(posedge clk_i) disable iff (reset_i)
    resp_ready_i |-> resp_v_i) else $error("response ready without valid");

  reset_quiet_a: assert property (@(posedge clk_i) reset_i ##1 reset_i
    |-> !(cmd_v_i | data_v_i | req_ready_i | resp_ready_i | halted_i))
    else $error("outputs active during reset");

endmodule

// ==== cce_exec.sv ====
/*
  register file, ALU and branch resolution
  four 16-bit registers, cleared by reset
  writes follow the decoded one-hot mask, which is zero on a stalled instruction
  outgoing payload is always register src_a, qualified by the push valids
*/
`timescale 1ns/1ps

module cce_exec
  import cce_pkg::*;
  (input                  clk_i
   , input                reset_i
   , input cce_decoded_s  decoded_i
   , input                decoded_v_i
   // input queue payloads
   , input cce_msg_s      req_i
   , input cce_msg_s      resp_i
   , output logic         branch_taken_o
   , output cce_msg_s     out_msg_o
  );

  logic [cce_data_width_c-1:0] gpr_r [4];
  logic [cce_data_width_c-1:0] src_a, src_b;
  logic [cce_data_width_c-1:0] alu_res;
  logic [cce_data_width_c-1:0] wr_data;
  logic                        branch_cond;

  assign src_a = gpr_r[decoded_i.src_a];
  assign src_b = gpr_r[decoded_i.src_b];

  always_comb begin
    alu_res = '0;
    if (decoded_i.alu_v) begin
      case (decoded_i.alu_op.alu)
        e_add_op: alu_res = src_a + src_b;
        e_sub_op: alu_res = src_a - src_b;
        e_and_op: alu_res = src_a & src_b;
        e_or_op:  alu_res = src_a | src_b;
        default:  alu_res = '0;
      endcase
    end
  end

  always_comb begin
    case (decoded_i.alu_op.branch)
      e_beq_op: branch_cond = src_a == src_b;
      e_bne_op: branch_cond = src_a != src_b;
      e_bi_op:  branch_cond = 1'b1;
      default:  branch_cond = 1'b0;
    endcase
    branch_taken_o = decoded_v_i & decoded_i.branch_v & branch_cond;
  end

  always_comb begin
    case (decoded_i.gpr_w_sel)
      e_gpr_w_imm:   wr_data = decoded_i.imm;
      e_gpr_w_queue: wr_data = (decoded_i.pop_src == e_src_q_req) ? req_i.payload
                                                                   : resp_i.payload;
      default:       wr_data = alu_res;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < 4; i++) begin
        gpr_r[i] <= '0;
      end
    end else begin
      for (int i = 0; i < 4; i++) begin
        if (decoded_i.gpr_w_mask[i]) begin
          gpr_r[i] <= wr_data;
        end
      end
    end
  end

  assign out_msg_o.payload = src_a;

endmodule

// ==== cce_inst_decode.sv ====
/*
  combinational instruction decode and PC stall
  output queues follow ready-then-valid: push valid only rises with ready
  pop ready only rises with the selected input valid
  register writes are zeroed whenever the instruction stalls
  halted flag is set one cycle after stop is decoded and cleared by reset only
*/
`timescale 1ns/1ps

module cce_inst_decode
  import cce_pkg::*;
  #(parameter int prog_addr_width_p = 6)
  (input                  clk_i
   , input                reset_i
   , input cce_inst_s     inst_i
   , input                inst_v_i
   // input queue valids
   , input                req_v_i
   , input                resp_v_i
   // output queue readies
   , input                cmd_ready_i
   , input                data_ready_i
   , output cce_decoded_s decoded_o
   , output logic         decoded_v_o
   , output logic         pc_stall_o
   , output logic         halted_o
  );

  logic is_alu, is_branch, is_move;
  logic wfq_op, popq_op, pushq_op, stop_op;
  cce_src_q_e pop_sel;
  cce_dst_q_e push_sel;
  logic pop_q_v, push_q_ready, wfq_hit;
  logic gpr_w_v;
  logic halted_r;

  always_comb begin
    is_alu    = inst_i.op == e_op_alu;
    is_branch = inst_i.op == e_op_branch;
    is_move   = inst_i.op == e_op_move;
    wfq_op    = (inst_i.op == e_op_queue) && (inst_i.minor_op.queue == e_wfq_op);
    popq_op   = (inst_i.op == e_op_queue) && (inst_i.minor_op.queue == e_popq_op);
    pushq_op  = (inst_i.op == e_op_queue) && (inst_i.minor_op.queue == e_pushq_op);
    stop_op   = (inst_i.op == e_op_misc) && (inst_i.minor_op.misc == e_stop_op);

    pop_sel  = cce_src_q_e'(inst_i.imm[0]);
    push_sel = cce_dst_q_e'(inst_i.imm[0]);

    pop_q_v      = (pop_sel == e_src_q_req) ? req_v_i : resp_v_i;
    push_q_ready = (push_sel == e_dst_q_cmd) ? cmd_ready_i : data_ready_i;
    // mask bit 1 is request, bit 0 is response
    wfq_hit = |(inst_i.imm[1:0] & {req_v_i, resp_v_i});

    pc_stall_o = inst_v_i & (stop_op
                             | (wfq_op & ~wfq_hit)
                             | (popq_op & ~pop_q_v)
                             | (pushq_op & ~push_q_ready));
    decoded_v_o = inst_v_i & ~pc_stall_o;
  end

  always_comb begin
    decoded_o = '0;
    gpr_w_v   = decoded_v_o & (is_alu | is_move | popq_op);
    if (inst_v_i) begin
      decoded_o.alu_v    = is_alu;
      decoded_o.branch_v = is_branch;
      decoded_o.alu_op   = inst_i.minor_op;
      decoded_o.src_a    = inst_i.src_a;
      decoded_o.src_b    = inst_i.src_b;
      decoded_o.dst      = inst_i.dst;
      // branch imm is trimmed to the program address range
      if (is_branch) begin
        decoded_o.imm = {{(cce_data_width_c-prog_addr_width_p){1'b0}},
                         inst_i.imm[prog_addr_width_p-1:0]};
      end else begin
        decoded_o.imm = inst_i.imm;
      end

      decoded_o.gpr_w_mask = gpr_w_v ? (4'b0001 << inst_i.dst) : 4'b0000;
      if (is_move) begin
        decoded_o.gpr_w_sel = e_gpr_w_imm;
      end else if (popq_op) begin
        decoded_o.gpr_w_sel = e_gpr_w_queue;
      end else begin
        decoded_o.gpr_w_sel = e_gpr_w_alu;
      end
      decoded_o.pop_src = pop_sel;

      // dequeue only in the cycle the selected queue is valid
      decoded_o.req_ready  = popq_op & (pop_sel == e_src_q_req) & req_v_i;
      decoded_o.resp_ready = popq_op & (pop_sel == e_src_q_resp) & resp_v_i;
      // enqueue only in the cycle the selected queue is ready
      decoded_o.cmd_v  = pushq_op & (push_sel == e_dst_q_cmd) & cmd_ready_i;
      decoded_o.data_v = pushq_op & (push_sel == e_dst_q_data) & data_ready_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      halted_r <= 1'b0;
    end else if (inst_v_i && stop_op) begin
      halted_r <= 1'b1;
    end
  end

  assign halted_o = halted_r;

endmodule

// ==== cce_pc.sv ====
/*
  program memory and program counter
  program is loaded only while run_i is low, no read-during-write handling
  execution starts at address 0 one cycle after run_i rises
  branch target comes from the low bits of the instruction imm
*/
`timescale 1ns/1ps

module cce_pc
  import cce_pkg::*;
  #(parameter int prog_addr_width_p = 6)
  (input                                clk_i
   , input                              reset_i
   , input                              run_i
   // program load port
   , input                              load_v_i
   , input [prog_addr_width_p-1:0]      load_addr_i
   , input [cce_inst_width_c-1:0]       load_inst_i
   // control from decode and execute
   , input                              pc_stall_i
   , input                              branch_taken_i
   , output cce_inst_s                  inst_o
   , output logic                       inst_v_o
  );

  localparam int prog_depth_lp = 2 ** prog_addr_width_p;

  logic [cce_inst_width_c-1:0] prog_mem [prog_depth_lp];

  logic [prog_addr_width_p-1:0] pc_r;
  logic [prog_addr_width_p-1:0] pc_next;
  logic                         run_r;

  always_ff @(posedge clk_i) begin
    if (load_v_i && !run_i) begin
      prog_mem[load_addr_i] <= load_inst_i;
    end
  end

  // asynchronous read of the current instruction
  assign inst_o   = cce_inst_s'(prog_mem[pc_r]);
  assign inst_v_o = run_r;

  always_comb begin
    if (!run_r) begin
      pc_next = '0;
    end else if (pc_stall_i) begin
      pc_next = pc_r;
    end else if (branch_taken_i) begin
      pc_next = inst_o.imm[prog_addr_width_p-1:0];
    end else begin
      pc_next = pc_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_r  <= '0;
      run_r <= 1'b0;
    end else begin
      pc_r  <= pc_next;
      run_r <= run_i;
    end
  end

endmodule

// ==== cce_pkg.sv ====
/*
  shared types for the microcoded coherence core
  instruction is 28 bits: op, minor op, three register fields and a 16-bit imm
  minor opcodes overlap between classes, so the minor op is a union of enums
  imm also carries branch target, wfq mask {req, resp} and queue select in bit 0
*/
package cce_pkg;

  localparam int cce_data_width_c = 16;
  localparam int cce_inst_width_c = 28;

  typedef enum logic [2:0] {
    e_op_alu    = 3'd0,
    e_op_branch = 3'd1,
    e_op_move   = 3'd2,
    e_op_queue  = 3'd3,
    e_op_misc   = 3'd4
  } cce_op_e;

  typedef enum logic [2:0] {
    e_add_op = 3'd0,
    e_sub_op = 3'd1,
    e_and_op = 3'd2,
    e_or_op  = 3'd3
  } cce_alu_op_e;

  typedef enum logic [2:0] {
    e_beq_op = 3'd0,
    e_bne_op = 3'd1,
    e_bi_op  = 3'd2
  } cce_branch_op_e;

  typedef enum logic [2:0] {
    e_wfq_op   = 3'd0,
    e_popq_op  = 3'd1,
    e_pushq_op = 3'd2
  } cce_queue_op_e;

  typedef enum logic [2:0] {
    e_stop_op = 3'd0
  } cce_misc_op_e;

  // one 3-bit field, read according to the major op
  typedef union packed {
    cce_alu_op_e    alu;
    cce_branch_op_e branch;
    cce_queue_op_e  queue;
    cce_misc_op_e   misc;
  } cce_minor_op_e;

  typedef enum logic [1:0] {e_r0, e_r1, e_r2, e_r3} cce_gpr_e;

  typedef enum logic {e_src_q_req, e_src_q_resp} cce_src_q_e;

  typedef enum logic {e_dst_q_cmd, e_dst_q_data} cce_dst_q_e;

  // register write source
  typedef enum logic [1:0] {e_gpr_w_alu, e_gpr_w_imm, e_gpr_w_queue} cce_gpr_w_sel_e;

  typedef struct packed {
    cce_op_e                     op;
    cce_minor_op_e               minor_op;
    cce_gpr_e                    dst;
    cce_gpr_e                    src_a;
    cce_gpr_e                    src_b;
    logic [cce_data_width_c-1:0] imm;
  } cce_inst_s;

  typedef struct packed {
    logic [cce_data_width_c-1:0] payload;
  } cce_msg_s;

  typedef struct packed {
    logic                        alu_v;
    logic                        branch_v;
    // minor op of alu and branch instructions
    cce_minor_op_e               alu_op;
    cce_gpr_e                    src_a;
    cce_gpr_e                    src_b;
    cce_gpr_e                    dst;
    logic [cce_data_width_c-1:0] imm;
    logic [3:0]                  gpr_w_mask;
    cce_gpr_w_sel_e              gpr_w_sel;
    cce_src_q_e                  pop_src;
    logic                        req_ready;
    logic                        resp_ready;
    logic                        cmd_v;
    logic                        data_v;
  } cce_decoded_s;

endpackage

// ==== cce_top.f ====
cce_pkg.sv
cce_pc.sv
cce_inst_decode.sv
cce_exec.sv
cce_top.sv
tb_clock_gen.sv
cce_assert_checker.sv
tb_cce_top.sv

// ==== cce_top.sv ====
/*
  microcoded coherence core top level
  load the program with run_i low, then raise run_i to execute from address 0
  all queues use valid/ready; a transfer happens when both are high
  command and data outputs share one payload, only the matching valid is raised
*/
`timescale 1ns/1ps

module cce_top
  import cce_pkg::*;
  #(parameter int prog_addr_width_p = 6)
  (input                              clk_i
   , input                            reset_i
   , input                            run_i
   , output logic                     halted_o
   // program load port
   , input                            load_v_i
   , input [prog_addr_width_p-1:0]    load_addr_i
   , input [cce_inst_width_c-1:0]     load_inst_i
   // input queues
   , input cce_msg_s                  req_i
   , input                            req_v_i
   , output logic                     req_ready_o
   , input cce_msg_s                  resp_i
   , input                            resp_v_i
   , output logic                     resp_ready_o
   // output queues
   , output cce_msg_s                 cmd_o
   , output logic                     cmd_v_o
   , input                            cmd_ready_i
   , output cce_msg_s                 data_o
   , output logic                     data_v_o
   , input                            data_ready_i
  );

  cce_inst_s    inst;
  logic         inst_v;
  cce_decoded_s decoded;
  logic         decoded_v;
  logic         pc_stall;
  logic         branch_taken;
  cce_msg_s     out_msg;

  cce_pc #(.prog_addr_width_p(prog_addr_width_p)) pc (
    .clk_i, .reset_i, .run_i, .load_v_i, .load_addr_i, .load_inst_i
    , .pc_stall_i(pc_stall), .branch_taken_i(branch_taken)
    , .inst_o(inst), .inst_v_o(inst_v));

  cce_inst_decode #(.prog_addr_width_p(prog_addr_width_p)) inst_decode (
    .clk_i, .reset_i, .inst_i(inst), .inst_v_i(inst_v)
    , .req_v_i, .resp_v_i, .cmd_ready_i, .data_ready_i
    , .decoded_o(decoded), .decoded_v_o(decoded_v)
    , .pc_stall_o(pc_stall), .halted_o);

  cce_exec exec (
    .clk_i, .reset_i, .decoded_i(decoded), .decoded_v_i(decoded_v)
    , .req_i, .resp_i, .branch_taken_o(branch_taken), .out_msg_o(out_msg));

  assign req_ready_o  = decoded.req_ready;
  assign resp_ready_o = decoded.resp_ready;
  assign cmd_v_o      = decoded.cmd_v;
  assign data_v_o     = decoded.data_v;
  assign cmd_o        = out_msg;
  assign data_o       = out_msg;

endmodule

// ==== tb_cce_top.sv ====
/*
  testbench for cce_top with an instruction-level model
  programs use a 6-bit address space and must end in stop
  input messages are held valid until taken, payloads come from an LFSR
  the first error ends the run
*/
`timescale 1ns/1ps

module tb_cce_top
  import cce_pkg::*;
  ();

  localparam int prog_addr_width_lp = 6;

  logic clk, gen_reset, tb_reset;
  logic run_i, load_v_i, halted_o;
  logic [prog_addr_width_lp-1:0] load_addr_i;
  logic [cce_inst_width_c-1:0]   load_inst_i;
  cce_msg_s req_i, resp_i, cmd_o, data_o;
  logic req_v_i, req_ready_o, resp_v_i, resp_ready_o;
  logic cmd_v_o, cmd_ready_i, data_v_o, data_ready_i;

  logic [31:0] lfsr_q;
  logic        bp_en;
  int          req_idx, resp_idx, model_steps;
  cce_inst_s   prog [$];
  cce_msg_s    req_q [$], resp_q [$], exp_cmd [$], exp_data [$];

  tb_clock_gen clock_gen (.clk_o(clk), .reset_o(gen_reset));

  cce_top #(.prog_addr_width_p(prog_addr_width_lp)) uut (
    .clk_i(clk), .reset_i(gen_reset | tb_reset), .run_i, .halted_o
    , .load_v_i, .load_addr_i, .load_inst_i
    , .req_i, .req_v_i, .req_ready_o, .resp_i, .resp_v_i, .resp_ready_o
    , .cmd_o, .cmd_v_o, .cmd_ready_i, .data_o, .data_v_o, .data_ready_i);

  bind cce_top cce_assert_checker checker_i (
    .clk_i, .reset_i, .req_v_i, .req_ready_i(req_ready_o), .resp_v_i
    , .resp_ready_i(resp_ready_o), .cmd_v_i(cmd_v_o), .cmd_ready_i
    , .data_v_i(data_v_o), .data_ready_i, .halted_i(halted_o));

  // galois LFSR, one step per bit
  function automatic logic rand_bit();
    logic out;
    out = lfsr_q[0];
    lfsr_q = (lfsr_q >> 1) ^ (out ? 32'h8020_0003 : 32'h0);
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], rand_bit()};
    end
    return v;
  endfunction

  function automatic cce_inst_s encode_inst(input cce_op_e op, input logic [2:0] mnr,
      input logic [1:0] dst, input logic [1:0] a, input logic [1:0] b,
      input logic [15:0] imm);
    return {op, mnr, dst, a, b, imm};
  endfunction

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_msg(input string name, input cce_msg_s exp, input cce_msg_s act);
    if (act !== exp) begin
      abort_run($sformatf("mismatch %s expected %h actual %h", name, exp.payload,
                          act.payload));
    end
  endtask

  task automatic check_halt(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      abort_run($sformatf("mismatch %s halted expected %b actual %b", name, exp, act));
    end
  endtask

  // four random moves, then random ALU ops each pushed to the command queue
  task automatic build_alu_prog();
    logic [1:0] d, a, b;
    logic [2:0] op;
    prog.delete();
    req_q.delete();
    resp_q.delete();
    for (int i = 0; i < 4; i++) begin
      prog.push_back(encode_inst(e_op_move, 3'd0, 2'(i), 2'd0, 2'd0, 16'(rand_bits(16))));
    end
    for (int i = 0; i < 6; i++) begin
      op = 3'(rand_bits(2));
      d = 2'(rand_bits(2));
      a = 2'(rand_bits(2));
      b = 2'(rand_bits(2));
      prog.push_back(encode_inst(e_op_alu, op, d, a, b, 16'd0));
      prog.push_back(encode_inst(e_op_queue, e_pushq_op, 2'd0, d, 2'd0, 16'd0));
    end
    prog.push_back(encode_inst(e_op_misc, e_stop_op, 2'd0, 2'd0, 2'd0, 16'd0));
  endtask

  // bne loop on cmd, then beq/bi loop on data, both counting to cnt
  task automatic build_branch_prog();
    logic [15:0] cnt;
    cnt = 16'(rand_bits(3)) + 16'd1;
    prog.delete();
    req_q.delete();
    resp_q.delete();
    prog.push_back(encode_inst(e_op_move, 3'd0, 2'd0, 2'd0, 2'd0, 16'd0));
    prog.push_back(encode_inst(e_op_move, 3'd0, 2'd1, 2'd0, 2'd0, 16'd1));
    prog.push_back(encode_inst(e_op_move, 3'd0, 2'd2, 2'd0, 2'd0, cnt));
    prog.push_back(encode_inst(e_op_alu, e_add_op, 2'd0, 2'd0, 2'd1, 16'd0));
    prog.push_back(encode_inst(e_op_queue, e_pushq_op, 2'd0, 2'd0, 2'd0, 16'd0));
    prog.push_back(encode_inst(e_op_branch, e_bne_op, 2'd0, 2'd0, 2'd2, 16'd3));
    prog.push_back(encode_inst(e_op_move, 3'd0, 2'd3, 2'd0, 2'd0, 16'd0));
    prog.push_back(encode_inst(e_op_alu, e_add_op, 2'd3, 2'd3, 2'd1, 16'd0));
    prog.push_back(encode_inst(e_op_queue, e_pushq_op, 2'd0, 2'd3, 2'd0, 16'd1));
    prog.push_back(encode_inst(e_op_branch, e_beq_op, 2'd0, 2'd3, 2'd2, 16'd11));
    prog.push_back(encode_inst(e_op_branch, e_bi_op, 2'd0, 2'd0, 2'd0, 16'd7));
    prog.push_back(encode_inst(e_op_misc, e_stop_op, 2'd0, 2'd0, 2'd0, 16'd0));
  endtask

  // request goes to cmd, response goes to data, n times each
  task automatic build_echo_prog();
    int       n;
    cce_msg_s m;
    n = 4 + int'(rand_bits(2));
    prog.delete();
    req_q.delete();
    resp_q.delete();
    for (int i = 0; i < n; i++) begin
      m.payload = 16'(rand_bits(16));
      req_q.push_back(m);
      m.payload = 16'(rand_bits(16));
      resp_q.push_back(m);
    end
    prog.push_back(encode_inst(e_op_move, 3'd0, 2'd3, 2'd0, 2'd0, 16'(n)));
    prog.push_back(encode_inst(e_op_move, 3'd0, 2'd1, 2'd0, 2'd0, 16'd1));
    prog.push_back(encode_inst(e_op_queue, e_wfq_op, 2'd0, 2'd0, 2'd0, 16'd3));
    prog.push_back(encode_inst(e_op_queue, e_popq_op, 2'd0, 2'd0, 2'd0, 16'd0));
    prog.push_back(encode_inst(e_op_queue, e_pushq_op, 2'd0, 2'd0, 2'd0, 16'd0));
    prog.push_back(encode_inst(e_op_queue, e_wfq_op, 2'd0, 2'd0, 2'd0, 16'd1));
    prog.push_back(encode_inst(e_op_queue, e_popq_op, 2'd0, 2'd0, 2'd0, 16'd1));
    prog.push_back(encode_inst(e_op_queue, e_pushq_op, 2'd0, 2'd0, 2'd0, 16'd1));
    prog.push_back(encode_inst(e_op_alu, e_add_op, 2'd2, 2'd2, 2'd1, 16'd0));
    prog.push_back(encode_inst(e_op_branch, e_bne_op, 2'd0, 2'd2, 2'd3, 16'd2));
    prog.push_back(encode_inst(e_op_misc, e_stop_op, 2'd0, 2'd0, 2'd0, 16'd0));
  endtask

  // executes prog on its own registers and fills the expected output queues
  task automatic run_model();
    logic [15:0] r [4];
    logic [15:0] a, b;
    int          pc, ri, si;
    logic        done, taken;
    cce_inst_s   ins;
    cce_msg_s    m;
    r = '{default: '0};
    pc = 0;
    ri = 0;
    si = 0;
    done = 1'b0;
    model_steps = 0;
    exp_cmd.delete();
    exp_data.delete();
    while (!done) begin
      ins = prog[pc];
      a = r[ins.src_a];
      b = r[ins.src_b];
      pc = pc + 1;
      model_steps++;
      case (ins.op)
        e_op_alu: begin
          case (ins.minor_op.alu)
            e_add_op: r[ins.dst] = a + b;
            e_sub_op: r[ins.dst] = a - b;
            e_and_op: r[ins.dst] = a & b;
            default:  r[ins.dst] = a | b;
          endcase
        end
        e_op_move: r[ins.dst] = ins.imm;
        e_op_branch: begin
          taken = (ins.minor_op.branch == e_bi_op)
                  || ((ins.minor_op.branch == e_beq_op) && (a == b))
                  || ((ins.minor_op.branch == e_bne_op) && (a != b));
          if (taken) begin
            pc = int'(ins.imm[prog_addr_width_lp-1:0]);
          end
        end
        e_op_queue: begin
          m.payload = a;
          if (ins.minor_op.queue == e_popq_op && ins.imm[0]) begin
            r[ins.dst] = resp_q[si].payload;
            si++;
          end else if (ins.minor_op.queue == e_popq_op) begin
            r[ins.dst] = req_q[ri].payload;
            ri++;
          end else if (ins.minor_op.queue == e_pushq_op && ins.imm[0]) begin
            exp_data.push_back(m);
          end else if (ins.minor_op.queue == e_pushq_op) begin
            exp_cmd.push_back(m);
          end
        end
        default: done = 1'b1;
      endcase
      if (model_steps > 2000) begin
        abort_run("reference model never reached a stop instruction");
      end
    end
  endtask

  task automatic apply_reset(input string name);
    @(posedge clk);
    #1;
    tb_reset = 1'b1;
    run_i = 1'b0;
    load_v_i = 1'b0;
    req_v_i = 1'b0;
    resp_v_i = 1'b0;
    repeat (4) @(posedge clk);
    @(negedge clk);
    check_halt(name, 1'b0, halted_o);
    @(posedge clk);
    #1;
    tb_reset = 1'b0;
  endtask

  task automatic load_program();
    foreach (prog[i]) begin
      @(posedge clk);
      #1;
      load_v_i = 1'b1;
      load_addr_i = prog_addr_width_lp'(i);
      load_inst_i = prog[i];
    end
    @(posedge clk);
    #1;
    load_v_i = 1'b0;
  endtask

  // a held valid changes only after its transfer
  task automatic drive_queues(input logic req_took, input logic resp_took);
    if (!req_v_i || req_took) begin
      req_v_i = (req_idx < req_q.size()) && rand_bit();
    end
    if (!resp_v_i || resp_took) begin
      resp_v_i = (resp_idx < resp_q.size()) && rand_bit();
    end
    req_i = (req_idx < req_q.size()) ? req_q[req_idx] : '0;
    resp_i = (resp_idx < resp_q.size()) ? resp_q[resp_idx] : '0;
    cmd_ready_i = bp_en ? rand_bit() : 1'b1;
    data_ready_i = bp_en ? rand_bit() : 1'b1;
  endtask

  // abort_at > 0 stops the run early without the end checks
  task automatic execute(input string name, input int abort_at);
    int   cyc, after_halt, limit;
    logic req_took, resp_took, done;
    cyc = 0;
    after_halt = 0;
    limit = model_steps * 16 + 64;
    req_idx = 0;
    resp_idx = 0;
    req_took = 1'b0;
    resp_took = 1'b0;
    done = 1'b0;
    @(posedge clk);
    #1;
    run_i = 1'b1;
    while (!done) begin
      drive_queues(req_took, resp_took);
      @(negedge clk);
      req_took = req_v_i & req_ready_o;
      resp_took = resp_v_i & resp_ready_o;
      if (req_took) req_idx++;
      if (resp_took) resp_idx++;
      if (cmd_v_o) begin
        if (!cmd_ready_i || halted_o || exp_cmd.size() == 0) begin
          abort_run({"unexpected command message in ", name});
        end
        check_msg(name, exp_cmd.pop_front(), cmd_o);
      end
      if (data_v_o) begin
        if (!data_ready_i || halted_o || exp_data.size() == 0) begin
          abort_run({"unexpected data message in ", name});
        end
        check_msg(name, exp_data.pop_front(), data_o);
      end
      if (halted_o) after_halt++;
      done = (after_halt == 4) || (abort_at > 0 && cyc == abort_at);
      cyc++;
      if (cyc > limit) begin
        abort_run({"timeout, the core never halted in ", name});
      end
      if (!done) begin
        @(posedge clk);
        #1;
      end
    end
    if (abort_at == 0) begin
      if (exp_cmd.size() != 0 || exp_data.size() != 0) begin
        abort_run({"expected output messages never appeared in ", name});
      end
      if (req_idx != req_q.size() || resp_idx != resp_q.size()) begin
        abort_run({"input messages were not all consumed in ", name});
      end
      check_halt(name, 1'b1, halted_o);
    end
  endtask

  task automatic run_test(input string name, input int abort_at);
    run_model();
    apply_reset(name);
    load_program();
    execute(name, abort_at);
  endtask

  initial begin
    lfsr_q = 32'hacb8_cc7d;
    tb_reset = 1'b0;
    run_i = 1'b0;
    load_v_i = 1'b0;
    load_addr_i = '0;
    load_inst_i = '0;
    req_i = '0;
    resp_i = '0;
    req_v_i = 1'b0;
    resp_v_i = 1'b0;
    cmd_ready_i = 1'b0;
    data_ready_i = 1'b0;
    bp_en = 1'b0;
    wait (gen_reset === 1'b0);

    build_alu_prog();
    run_test("alu_move", 0);
    build_branch_prog();
    run_test("branch", 0);
    build_echo_prog();
    run_test("input_queues", 0);
    bp_en = 1'b1;
    build_echo_prog();
    run_test("back_pressure", 0);
    // reset partway through, then reload and rerun the same program
    build_alu_prog();
    run_test("stop_reset", 7);
    run_test("stop_reset", 0);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== tb_clock_gen.sv ====
/*
  testbench clock and power-on reset
  100 ns period, reset high for the first 5 rising edges
*/
`timescale 1ns/1ps

module tb_clock_gen
  (output logic   clk_o
   , output logic reset_o
  );

  initial begin
    clk_o = 1'b0;
    forever #50 clk_o = ~clk_o;
  end

  initial begin
    reset_o = 1'b1;
    repeat (5) @(posedge clk_o);
    #1 reset_o = 1'b0;
  end

endmodule
